/* design/fpAddConfig.svh */
// Single-precision format constants for the pipelined FP adder
// Word, exponent, fraction and working significand widths
`ifndef FP_ADD_CONFIG_SVH
`define FP_ADD_CONFIG_SVH

// IEEE-754 single precision layout
`define FP_WIDTH 32
`define FP_EXP_WIDTH 8
`define FP_FRAC_WIDTH 23

// Hidden one, fraction, two guard zeros
`define FP_SIG_WIDTH 26
// Enough to count 0..31 positions
`define FP_SHIFT_WIDTH 5

// All-ones exponent, reserved for infinity
`define FP_EXP_MAX 255

`endif

/* design/fpAddPkg.sv */
// Shared types for the pipelined FP adder/subtractor
// Plain vector widths plus the structs passed between stages
`include "fpAddConfig.svh"

package fpAddPkg;

  typedef logic [`FP_WIDTH-1:0] wordT;
  typedef logic [`FP_WIDTH-2:0] magT;
  typedef logic [`FP_EXP_WIDTH-1:0] expT;
  typedef logic [`FP_FRAC_WIDTH-1:0] fracT;
  typedef logic [`FP_SIG_WIDTH-1:0] sigT;
  typedef logic [`FP_SHIFT_WIDTH-1:0] shiftT;

  // Sort stage to align stage
  typedef struct packed {
    logic valid;
    logic sign;
    logic effSub;
    logic zero;
    magT  bigMag;
    magT  smallMag;
  } sortStageT;

  // Align stage to significand add stage
  typedef struct packed {
    logic valid;
    logic sign;
    logic effSub;
    logic zero;
    expT  exp;
    sigT  bigSig;
    sigT  smallSig;
  } alignStageT;

  // Significand add stage to normalize stage
  typedef struct packed {
    logic valid;
    logic sign;
    logic zero;
    expT  exp;
    logic carry;
    sigT  rawSig;
  } sumStageT;

endpackage

/* design/barrelShifter.sv */
// Logarithmic shifter over the working significand
// One mux level per amount bit, zero fill, direction fixed
// at elaboration; amounts past the width give zero
`timescale 1ns/1ps
`include "fpAddConfig.svh"

module barrelShifter #(
  parameter bit shiftLeft = 1'b0
) (
  input  fpAddPkg::sigT   data_i,
  input  fpAddPkg::shiftT amount_i,
  output fpAddPkg::sigT   data_o
);

  // Level k holds data after the low k amount bits
  fpAddPkg::sigT levelData [0:`FP_SHIFT_WIDTH];

  assign levelData[0] = data_i;

  for (genvar k = 0; k < `FP_SHIFT_WIDTH; k++) begin : gLevel
    if (shiftLeft) begin : gLeft
      // Normalization toward the hidden one
      assign levelData[k+1] = amount_i[k] ? (levelData[k] << (1 << k)) : levelData[k];
    end else begin : gRight
      // Alignment toward the guard bits
      assign levelData[k+1] = amount_i[k] ? (levelData[k] >> (1 << k)) : levelData[k];
    end
  end

  // 16+8+2 already pushes every bit out
  assign data_o = levelData[`FP_SHIFT_WIDTH];

endmodule

/* design/fpOperandSort.sv */
// First pipeline stage of the FP adder
// Orders the operands by magnitude and works out the
// effective operation, result sign and exact-cancellation flag
`timescale 1ns/1ps
`include "fpAddConfig.svh"

module fpOperandSort (
  input  logic                clk,
  input  logic                reset_i,
  input  logic                start_i,
  input  fpAddPkg::wordT      dataX_i,
  input  fpAddPkg::wordT      dataY_i,
  input  logic                addSub_i,
  output fpAddPkg::sortStageT sort_o
);

  logic          signX;
  logic          signY;
  fpAddPkg::magT magX;
  fpAddPkg::magT magY;
  logic          yBigger;
  logic          magEqual;
  logic          effSub;
  logic          resultSign;

  // ====================
  // Compare and classify
  // ====================

  assign signX = dataX_i[`FP_WIDTH-1];
  assign signY = dataY_i[`FP_WIDTH-1];
  assign magX  = dataX_i[`FP_WIDTH-2:0];
  assign magY  = dataY_i[`FP_WIDTH-2:0];

  // Exponent sits above fraction, so plain compare orders magnitude
  assign yBigger  = magY > magX;
  assign magEqual = magX == magY;

  // Real operation on the magnitudes
  assign effSub = signX ^ signY ^ addSub_i;

  // Y's sign flips when subtracting and Y dominates
  assign resultSign = yBigger ? (signY ^ addSub_i) : signX;

  // ====================
  // Stage register
  // ====================

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sort_o.valid <= 1'b0;
    end else begin
      sort_o.valid <= start_i;
    end
    // Payload only on a start
    if (start_i) begin
      sort_o.sign     <= resultSign;
      sort_o.effSub   <= effSub;
      sort_o.zero     <= effSub & magEqual;
      sort_o.bigMag   <= yBigger ? magY : magX;
      sort_o.smallMag <= yBigger ? magX : magY;
    end
  end

endmodule

/* design/fpAlign.sv */
// Second pipeline stage of the FP adder
// Exponent difference and right alignment of the smaller
// significand; differences past the significand width clear it
`timescale 1ns/1ps
`include "fpAddConfig.svh"

module fpAlign (
  input  logic                 clk,
  input  logic                 reset_i,
  input  fpAddPkg::sortStageT  sort_i,
  output fpAddPkg::alignStageT align_o
);

  fpAddPkg::expT   bigExp;
  fpAddPkg::expT   smallExp;
  fpAddPkg::fracT  bigFrac;
  fpAddPkg::fracT  smallFrac;
  fpAddPkg::expT   expDiff;
  fpAddPkg::shiftT shiftAmt;
  fpAddPkg::sigT   bigSig;
  fpAddPkg::sigT   smallSig;
  fpAddPkg::sigT   alignedSig;

  // Split magnitudes into fields
  assign bigExp    = sort_i.bigMag[`FP_WIDTH-2:`FP_FRAC_WIDTH];
  assign smallExp  = sort_i.smallMag[`FP_WIDTH-2:`FP_FRAC_WIDTH];
  assign bigFrac   = sort_i.bigMag[`FP_FRAC_WIDTH-1:0];
  assign smallFrac = sort_i.smallMag[`FP_FRAC_WIDTH-1:0];

  // Never negative, big has the larger magnitude
  assign expDiff = bigExp - smallExp;

  // Saturate so the high exponent bits are not lost
  assign shiftAmt = (expDiff >= `FP_SIG_WIDTH) ? fpAddPkg::shiftT'(`FP_SIG_WIDTH) :
                    expDiff[`FP_SHIFT_WIDTH-1:0];

  // Hidden one, fraction, two guard zeros
  assign bigSig   = {1'b1, bigFrac, 2'b00};
  assign smallSig = {1'b1, smallFrac, 2'b00};

  barrelShifter #(
    .shiftLeft (1'b0)
  ) rightShift (
    .data_i   (smallSig),
    .amount_i (shiftAmt),
    .data_o   (alignedSig)
  );

  // ====================
  // Stage register
  // ====================

  always_ff @(posedge clk) begin
    if (reset_i) begin
      align_o.valid <= 1'b0;
    end else begin
      align_o.valid <= sort_i.valid;
    end
    if (sort_i.valid) begin
      align_o.sign     <= sort_i.sign;
      align_o.effSub   <= sort_i.effSub;
      align_o.zero     <= sort_i.zero;
      align_o.exp      <= bigExp;
      align_o.bigSig   <= bigSig;
      align_o.smallSig <= alignedSig;
    end
  end

endmodule

/* design/fpSignificandAdd.sv */
// Third pipeline stage of the FP adder
// Adds or subtracts the aligned significands and keeps the
// carry out, meaningful for an effective addition only
`timescale 1ns/1ps
`include "fpAddConfig.svh"

module fpSignificandAdd (
  input  logic                 clk,
  input  logic                 reset_i,
  input  fpAddPkg::alignStageT align_i,
  output fpAddPkg::sumStageT   sum_o
);

  // One extra bit for the carry
  logic [`FP_SIG_WIDTH:0] sumWide;

  always_comb begin
    if (align_i.effSub) begin
      // Big minus small, never borrows
      sumWide = {1'b0, align_i.bigSig} - {1'b0, align_i.smallSig};
    end else begin
      sumWide = {1'b0, align_i.bigSig} + {1'b0, align_i.smallSig};
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sum_o.valid <= 1'b0;
    end else begin
      sum_o.valid <= align_i.valid;
    end
    if (align_i.valid) begin
      sum_o.sign   <= align_i.sign;
      sum_o.zero   <= align_i.zero;
      sum_o.exp    <= align_i.exp;
      // Ignore top bit on subtract
      sum_o.carry  <= sumWide[`FP_SIG_WIDTH] & ~align_i.effSub;
      sum_o.rawSig <= sumWide[`FP_SIG_WIDTH-1:0];
    end
  end

endmodule

/* design/fpNormalize.sv */
// Last pipeline stage of the FP adder
// Leading-zero count, normalizing shift, exponent adjust,
// overflow and underflow detection and IEEE packing into
// the output registers, with a one-cycle ready strobe
`timescale 1ns/1ps
`include "fpAddConfig.svh"

module fpNormalize (
  input  logic               clk,
  input  logic               reset_i,
  input  fpAddPkg::sumStageT sum_i,
  output fpAddPkg::wordT     result_o,
  output logic               ready_o,
  output logic               overflow_o,
  output logic               underflow_o,
  output logic               zero_o
);

  // Room for exponent plus one and minus 26
  localparam int expAdjWidth = `FP_EXP_WIDTH + 2;
  localparam logic signed [expAdjWidth-1:0] expMax = expAdjWidth'(`FP_EXP_MAX);

  fpAddPkg::shiftT               leadZeros;
  fpAddPkg::sigT                 leftSig;
  fpAddPkg::sigT                 normSig;
  fpAddPkg::fracT                resultFrac;
  logic signed [expAdjWidth-1:0] expAdj;
  logic                          overflow;
  logic                          underflow;
  fpAddPkg::wordT                packed_;

  // ====================
  // Leading zero count
  // ====================

  // Scan up from the LSB, last hit is the top one
  always_comb begin
    leadZeros = fpAddPkg::shiftT'(`FP_SIG_WIDTH);
    for (int i = 0; i < `FP_SIG_WIDTH; i++) begin
      if (sum_i.rawSig[i]) begin
        leadZeros = fpAddPkg::shiftT'(`FP_SIG_WIDTH - 1 - i);
      end
    end
  end

  barrelShifter #(
    .shiftLeft (1'b1)
  ) leftShift (
    .data_i   (sum_i.rawSig),
    .amount_i (leadZeros),
    .data_o   (leftSig)
  );

  // Carry goes back in on top
  assign normSig = sum_i.carry ? {1'b1, sum_i.rawSig[`FP_SIG_WIDTH-1:1]} : leftSig;

  // ====================
  // Exponent and flags
  // ====================

  always_comb begin
    if (sum_i.carry) begin
      expAdj = $signed({2'b00, sum_i.exp}) + 1;
    end else begin
      expAdj = $signed({2'b00, sum_i.exp}) -
               $signed({{(expAdjWidth - `FP_SHIFT_WIDTH){1'b0}}, leadZeros});
    end
  end

  assign overflow  = expAdj >= expMax;
  // Cancellation is reported as zero, not underflow
  assign underflow = (expAdj <= 0) & ~sum_i.zero;

  // Drop hidden one and guard bits
  assign resultFrac = normSig[`FP_SIG_WIDTH-2:2];

  always_comb begin
    if (sum_i.zero) begin
      packed_ = '0;
    end else if (overflow) begin
      // Signed infinity
      packed_ = {sum_i.sign, {`FP_EXP_WIDTH{1'b1}}, {`FP_FRAC_WIDTH{1'b0}}};
    end else if (underflow) begin
      packed_ = {sum_i.sign, {(`FP_WIDTH-1){1'b0}}};
    end else begin
      packed_ = {sum_i.sign, expAdj[`FP_EXP_WIDTH-1:0], resultFrac};
    end
  end

  // ====================
  // Output registers
  // ====================

  // Hold last result until the next valid one
  always_ff @(posedge clk) begin
    if (reset_i) begin
      ready_o     <= 1'b0;
      result_o    <= '0;
      overflow_o  <= 1'b0;
      underflow_o <= 1'b0;
      zero_o      <= 1'b0;
    end else begin
      ready_o <= sum_i.valid;
      if (sum_i.valid) begin
        result_o    <= packed_;
        overflow_o  <= overflow;
        underflow_o <= underflow;
        zero_o      <= sum_i.zero;
      end
    end
  end

endmodule

/* design/fpAddSubTop.sv */
// Pipelined single-precision FP adder/subtractor
// Four stages: operand sort, alignment, significand add
// and normalize. One new operation per cycle, results
// leave in issue order with a ready strobe
`timescale 1ns/1ps

module fpAddSubTop (
  input  logic           clk,
  input  logic           reset_i,
  input  logic           start_i,
  input  fpAddPkg::wordT dataX_i,
  input  fpAddPkg::wordT dataY_i,
  input  logic           addSub_i,
  output fpAddPkg::wordT result_o,
  output logic           ready_o,
  output logic           overflow_o,
  output logic           underflow_o,
  output logic           zero_o
);

  // Inter-stage buses, valid travels inside
  fpAddPkg::sortStageT  sortBus;
  fpAddPkg::alignStageT alignBus;
  fpAddPkg::sumStageT   sumBus;

  // ====================
  // Stage 1
  // ====================
  fpOperandSort sortStage (
    .clk       (clk),
    .reset_i   (reset_i),
    .start_i   (start_i),
    .dataX_i   (dataX_i),
    .dataY_i   (dataY_i),
    .addSub_i  (addSub_i),
    .sort_o    (sortBus)
  );

  // Stage 2
  fpAlign alignStage (
    .clk       (clk),
    .reset_i   (reset_i),
    .sort_i    (sortBus),
    .align_o   (alignBus)
  );

  // Stage 3
  fpSignificandAdd addStage (
    .clk       (clk),
    .reset_i   (reset_i),
    .align_i   (alignBus),
    .sum_o     (sumBus)
  );

  // ====================
  // Stage 4 and outputs
  // ====================
  fpNormalize normStage (
    .clk         (clk),
    .reset_i     (reset_i),
    .sum_i       (sumBus),
    .result_o    (result_o),
    .ready_o     (ready_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .zero_o      (zero_o)
  );

endmodule

/* tb/fpAddSubModel.svh */
// Reference model of the truncating FP adder/subtractor
// Works on unpacked fields with integer arithmetic, plus the
// LFSR step used for random operands
`ifndef FP_ADD_SUB_MODEL_SVH
`define FP_ADD_SUB_MODEL_SVH

`include "fpAddConfig.svh"

// Expected outputs of one operation
typedef struct packed {
  logic [`FP_WIDTH-1:0] result;
  logic                 overflow;
  logic                 underflow;
  logic                 zero;
} outcomeT;

// Fibonacci LFSR, taps 32 22 2 1, new bit enters at the bottom
function automatic logic [31:0] lfsrStep(input logic [31:0] state);
  logic feedback;
  feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], feedback};
endfunction

function automatic outcomeT modelAddSub(input logic [`FP_WIDTH-1:0] x,
                                        input logic [`FP_WIDTH-1:0] y,
                                        input logic op);
  logic [30:0] bigMag;
  logic [30:0] smallMag;
  logic        yBig;
  logic        effSub;
  logic        sign;
  logic        zero;
  int          bigExp;
  int          smallExp;
  int          bigSig;
  int          smallSig;
  int          raw;
  int          lz;
  int          norm;
  int          expOut;
  outcomeT     outcome;

  // Tie goes to X
  yBig     = y[30:0] > x[30:0];
  bigMag   = yBig ? y[30:0] : x[30:0];
  smallMag = yBig ? x[30:0] : y[30:0];
  effSub   = x[31] ^ y[31] ^ op;
  sign     = yBig ? (y[31] ^ op) : x[31];
  zero     = effSub && (x[30:0] == y[30:0]);

  // Hidden one on top, two zero guard bits below
  bigExp   = int'(bigMag[30:23]);
  smallExp = int'(smallMag[30:23]);
  bigSig   = ((1 << 23) + int'(bigMag[22:0])) * 4;
  smallSig = ((1 << 23) + int'(smallMag[22:0])) * 4;
  if (bigExp - smallExp >= `FP_SIG_WIDTH) begin
    smallSig = 0;
  end else begin
    smallSig = smallSig >> (bigExp - smallExp);
  end

  if (effSub) begin
    raw = bigSig - smallSig;
  end else begin
    raw = bigSig + smallSig;
  end

  // Carry past bit 25 only on an addition
  if (!effSub && raw >= (1 << `FP_SIG_WIDTH)) begin
    norm   = raw >> 1;
    expOut = bigExp + 1;
  end else begin
    lz = 0;
    while (lz < `FP_SIG_WIDTH && raw[25 - lz] == 1'b0) begin
      lz++;
    end
    norm   = (raw << lz) & ((1 << `FP_SIG_WIDTH) - 1);
    expOut = bigExp - lz;
  end

  outcome.overflow  = expOut >= `FP_EXP_MAX;
  outcome.underflow = (expOut <= 0) && !zero;
  outcome.zero      = zero;
  if (zero) begin
    outcome.result = '0;
  end else if (outcome.overflow) begin
    outcome.result = {sign, 8'hFF, 23'h0};
  end else if (outcome.underflow) begin
    outcome.result = {sign, 31'h0};
  end else begin
    outcome.result = {sign, expOut[7:0], norm[24:2]};
  end
  return outcome;
endfunction

`endif

/* tb/fpAddSubTb.sv */
// Testbench for the pipelined FP adder/subtractor
// Random and directed operations; model results wait in an
// in-order queue and assertions check every ready strobe
`timescale 1ns/1ps
`include "fpAddConfig.svh"

module fpAddSubTb;

  `include "fpAddSubModel.svh"

  // One queued expectation
  typedef struct packed {
    outcomeT     outcome;
    logic [31:0] issueCycle;
  } expectT;

  localparam int resetCycles  = 8;
  localparam int randomOps    = 200;
  localparam int burstOps     = 20;
  localparam int drainTimeout = 60;

  logic           clk = 1'b0;
  logic           reset_i;
  logic           start_i;
  fpAddPkg::wordT dataX_i;
  fpAddPkg::wordT dataY_i;
  logic           addSub_i;
  fpAddPkg::wordT result_o;
  logic           ready_o;
  logic           overflow_o;
  logic           underflow_o;
  logic           zero_o;

  logic [31:0] lfsrState   = 32'h77313a91;
  logic [31:0] cycleCount  = '0;
  // Bit k set means start was sampled k+1 edges ago
  logic [3:0]  startHist   = '0;
  logic        idleOutputs = 1'b0;
  expectT      expCur      = '0;
  expectT      expQ[$];

  always #5 clk = ~clk;

  fpAddSubTop dut_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .start_i     (start_i),
    .dataX_i     (dataX_i),
    .dataY_i     (dataY_i),
    .addSub_i    (addSub_i),
    .result_o    (result_o),
    .ready_o     (ready_o),
    .overflow_o  (overflow_o),
    .underflow_o (underflow_o),
    .zero_o      (zero_o)
  );

  // ====================
  // Helpers
  // ====================

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped on error");
  endtask

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrStep(lfsrState);
      bits      = {bits[30:0], lfsrState[0]};
    end
    return bits;
  endfunction

  // Normal operand with exponent 20..230
  function automatic fpAddPkg::wordT randomOperand();
    logic [31:0] draw;
    logic        sign;
    logic [7:0]  expVal;
    draw   = randomBits(1);
    sign   = draw[0];
    draw   = randomBits(8);
    expVal = 8'd20 + (draw[7:0] % 8'd211);
    draw   = randomBits(23);
    return {sign, expVal, draw[22:0]};
  endfunction

  task automatic issueOp(input fpAddPkg::wordT x, input fpAddPkg::wordT y, input logic op);
    expectT entry;
    @(posedge clk);
    start_i  <= 1'b1;
    dataX_i  <= x;
    dataY_i  <= y;
    addSub_i <= op;
    entry.outcome    = modelAddSub(x, y, op);
    entry.issueCycle = cycleCount;
    expQ.push_back(entry);
  endtask

  task automatic idleCycle();
    @(posedge clk);
    start_i <= 1'b0;
  endtask

  task automatic drainPipeline();
    int waited;
    idleCycle();
    waited = 0;
    while (expQ.size() != 0) begin
      @(posedge clk);
      waited++;
      if (waited > drainTimeout) begin
        abortRun($sformatf("Timed out waiting for %0d results", expQ.size()));
      end
    end
    // Last popped entry is checked an edge later
    @(posedge clk);
    @(posedge clk);
  endtask

  // ====================
  // Expectation tracking
  // ====================

  always @(posedge clk) begin
    cycleCount <= cycleCount + 32'd1;
    if (reset_i) begin
      startHist   <= '0;
      idleOutputs <= 1'b1;
    end else begin
      startHist <= {startHist[2:0], start_i};
      // Outputs load on this edge for the start three edges back
      if (startHist[2]) begin
        idleOutputs <= 1'b0;
        if (expQ.size() == 0) begin
          abortRun("A result was due but no operation was waiting for it");
        end else begin
          expCur <= expQ.pop_front();
        end
      end
    end
  end

  // ====================
  // Checks
  // ====================

  idleCheck: assert property (@(posedge clk) idleOutputs |->
    (!ready_o && !overflow_o && !underflow_o && !zero_o && result_o == '0))
    else abortRun($sformatf("[FAIL] %0t: outputs not cleared after reset", $time));

  readyCheck: assert property (@(posedge clk) disable iff (reset_i)
    ready_o == startHist[3])
    else abortRun($sformatf("[FAIL] %0t: ready_o is %b, expected %b",
                            $time, ready_o, startHist[3]));

  resultCheck: assert property (@(posedge clk) ready_o |->
    result_o == expCur.outcome.result)
    else abortRun($sformatf("[FAIL] %0t: result_o %h, expected %h (issued cycle %0d)",
                            $time, result_o, expCur.outcome.result, expCur.issueCycle));

  flagCheck: assert property (@(posedge clk) ready_o |->
    {overflow_o, underflow_o, zero_o} ==
    {expCur.outcome.overflow, expCur.outcome.underflow, expCur.outcome.zero})
    else abortRun($sformatf("[FAIL] %0t: flags ovf/unf/zero %b%b%b, expected %b%b%b",
                            $time, overflow_o, underflow_o, zero_o,
                            expCur.outcome.overflow, expCur.outcome.underflow,
                            expCur.outcome.zero));

  // ====================
  // Stimulus
  // ====================

  initial begin
    fpAddPkg::wordT x;
    fpAddPkg::wordT y;
    logic [31:0]    draw;
    reset_i  = 1'b1;
    start_i  = 1'b0;
    dataX_i  = '0;
    dataY_i  = '0;
    addSub_i = 1'b0;
    repeat (resetCycles) @(posedge clk);
    reset_i <= 1'b0;
    // Quiet stretch before the first start
    repeat (3) idleCycle();

    // Random mix with gaps of 0..3 idle cycles
    for (int n = 0; n < randomOps; n++) begin
      x    = randomOperand();
      y    = randomOperand();
      draw = randomBits(3);
      issueOp(x, y, draw[0]);
      repeat (int'(draw[2:1])) idleCycle();
    end
    drainPipeline();

    // Exact cancellation both ways
    for (int n = 0; n < 4; n++) begin
      x = randomOperand();
      issueOp(x, x, 1'b1);
      issueOp(x, {~x[31], x[30:0]}, 1'b0);
    end
    drainPipeline();

    // Exponent 254 with carry
    issueOp(32'h7F40_0000, 32'h7F60_0000, 1'b0);
    issueOp(32'hFF12_3456, 32'hFF00_0001, 1'b0);
    issueOp(32'h7F7F_FFFF, 32'hFF00_0000, 1'b1);
    // Exponent gaps of 26, 63 and 46 leave big unchanged
    issueOp(32'h4CAB_CDEF, 32'h3F80_0000, 1'b0);
    issueOp(32'h5F00_0000, 32'h3F80_0000, 1'b1);
    issueOp(32'hC123_4567, 32'h2A00_0000, 1'b1);
    issueOp(32'h4B00_0001, 32'h3E00_0000, 1'b0);
    drainPipeline();

    // Near-equal operands at exponent 1
    issueOp(32'h0080_0005, 32'h0080_0003, 1'b1);
    issueOp(32'h0080_0003, 32'h0080_0005, 1'b1);
    issueOp(32'h8080_0010, 32'h0080_000F, 1'b0);
    drainPipeline();

    // Back-to-back burst
    for (int n = 0; n < burstOps; n++) begin
      x    = randomOperand();
      y    = randomOperand();
      draw = randomBits(1);
      issueOp(x, y, draw[0]);
    end
    drainPipeline();

    if (expQ.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abortRun("Results still outstanding at the end of the run");
    end
  end

endmodule

/* vlog.f */
+incdir+design
+incdir+tb
design/fpAddPkg.sv
design/barrelShifter.sv
design/fpOperandSort.sv
design/fpAlign.sv
design/fpSignificandAdd.sv
design/fpNormalize.sv
design/fpAddSubTop.sv
tb/fpAddSubTb.sv

/* Makefile */
# Verilator build and run for the pipelined FP adder/subtractor

VERILATOR ?= verilator
TOP       ?= fpAddSubTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard design/*.sv design/*.svh tb/*.sv tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
